// File: Makefile
RTL = logic/llc_geom_pkg.sv logic/llc_msg_pkg.sv logic/llc_channel_buffer.sv \
      logic/llc_req_in_stage.sv logic/llc_rsp_in_stage.sv logic/llc_channels.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module llc_channels $(RTL)

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module llc_channels_tb \
		-o llc_channels_sim
	./obj_dir/llc_channels_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
logic/llc_geom_pkg.sv
logic/llc_msg_pkg.sv
logic/llc_channel_buffer.sv
logic/llc_req_in_stage.sv
logic/llc_rsp_in_stage.sv
logic/llc_channels.sv
test/llc_channels_properties.sv
test/llc_channels_checker.sv
test/llc_channels_tb.sv

// File: logic/llc_channel_buffer.sv
/* Bypassable depth-one queue for one valid/ready channel */

`timescale 1ns/1ps
`default_nettype none

module llc_channel_buffer #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             src_valid_i,
    output logic             src_ready_o,
    input  logic [WIDTH-1:0] src_data_i,

    output logic             dst_valid_o,
    input  logic             dst_ready_i,
    output logic [WIDTH-1:0] dst_data_o
);

    logic             full_q;
    logic [WIDTH-1:0] slot_q;
    logic             park;

    // Source item arrives while the destination is blocked
    assign park = src_valid_i && src_ready_o && !dst_ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (full_q) begin
            // Slot drains when the destination takes it
            full_q <= !dst_ready_i;
        end else begin
            full_q <= park;
        end
    end

    always_ff @(posedge clk) begin
        if (park) begin
            slot_q <= src_data_i;
        end
    end

    assign src_ready_o = !full_q;

    // Held item first, otherwise straight through
    assign dst_valid_o = full_q || src_valid_i;
    assign dst_data_o = full_q ? slot_q : src_data_i;

endmodule

`default_nettype wire

// File: logic/llc_channels.sv
/* Channel stage top level: request and response inputs,
   memory request and forward outputs, field packing */

`timescale 1ns/1ps
`default_nettype none

module llc_channels
    import llc_geom_pkg::*, llc_msg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Coherence request from the network
    input  logic [COH_MSG_W-1:0]   req_in_coh_msg_i,
    input  logic [HPROT_W-1:0]     req_in_hprot_i,
    input  logic [LINE_ADDR_W-1:0] req_in_addr_i,
    input  logic [LINE_W-1:0]      req_in_line_i,
    input  logic [REQ_ID_W-1:0]    req_in_req_id_i,
    input  logic [WORD_OFF_W-1:0]  req_in_word_offset_i,
    input  logic [WORD_OFF_W-1:0]  req_in_valid_words_i,
    input  logic                   req_in_valid_i,
    output logic                   req_in_ready_o,

    // Captured request toward the controller
    output logic [COH_MSG_W-1:0]   req_coh_msg_o,
    output logic [HPROT_W-1:0]     req_hprot_o,
    output logic [LINE_ADDR_W-1:0] req_addr_o,
    output logic [LINE_W-1:0]      req_line_o,
    output logic [REQ_ID_W-1:0]    req_req_id_o,
    output logic [WORD_OFF_W-1:0]  req_word_offset_o,
    output logic [WORD_OFF_W-1:0]  req_valid_words_o,
    output logic                   req_valid_o,
    input  logic                   req_ready_i,
    input  logic                   set_stalled_i,
    input  logic                   replay_i,

    // Coherence response from the network and its captured copy
    input  logic [COH_MSG_W-1:0]   rsp_in_coh_msg_i,
    input  logic [LINE_ADDR_W-1:0] rsp_in_addr_i,
    input  logic [LINE_W-1:0]      rsp_in_line_i,
    input  logic [REQ_ID_W-1:0]    rsp_in_req_id_i,
    input  logic                   rsp_in_valid_i,
    output logic                   rsp_in_ready_o,
    output logic [COH_MSG_W-1:0]   rsp_coh_msg_o,
    output logic [LINE_ADDR_W-1:0] rsp_addr_o,
    output logic [LINE_W-1:0]      rsp_line_o,
    output logic [REQ_ID_W-1:0]    rsp_req_id_o,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,

    // Memory request, controller in and network out
    input  logic                   mem_req_hwrite_i,
    input  logic [HSIZE_W-1:0]     mem_req_hsize_i,
    input  logic [HPROT_W-1:0]     mem_req_hprot_i,
    input  logic [LINE_ADDR_W-1:0] mem_req_addr_i,
    input  logic [LINE_W-1:0]      mem_req_line_i,
    input  logic                   mem_req_valid_i,
    output logic                   mem_req_ready_o,
    output logic                   mem_req_hwrite_o,
    output logic [HSIZE_W-1:0]     mem_req_hsize_o,
    output logic [HPROT_W-1:0]     mem_req_hprot_o,
    output logic [LINE_ADDR_W-1:0] mem_req_addr_o,
    output logic [LINE_W-1:0]      mem_req_line_o,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,

    // Forward, controller in and network out
    input  logic [COH_MSG_W-1:0]   fwd_out_coh_msg_i,
    input  logic [LINE_ADDR_W-1:0] fwd_out_addr_i,
    input  logic [REQ_ID_W-1:0]    fwd_out_req_id_i,
    input  logic [DEST_ID_W-1:0]   fwd_out_dest_id_i,
    input  logic                   fwd_out_valid_i,
    output logic                   fwd_out_ready_o,
    output logic [COH_MSG_W-1:0]   fwd_out_coh_msg_o,
    output logic [LINE_ADDR_W-1:0] fwd_out_addr_o,
    output logic [REQ_ID_W-1:0]    fwd_out_req_id_o,
    output logic [DEST_ID_W-1:0]   fwd_out_dest_id_o,
    output logic                   fwd_out_valid_o,
    input  logic                   fwd_out_ready_i,

    // Look-ahead addresses
    output logic [LINE_ADDR_W-1:0] req_in_addr_o,
    output logic [LINE_ADDR_W-1:0] rsp_in_addr_o,
    output logic [LINE_ADDR_W-1:0] req_in_stalled_addr_o,
    output logic [LINE_ADDR_W-1:0] req_in_recall_addr_o
);

    logic [REQ_IN_W-1:0]  req_in_data;
    logic [REQ_IN_W-1:0]  req_data;
    logic [RSP_IN_W-1:0]  rsp_in_data;
    logic [RSP_IN_W-1:0]  rsp_data;
    logic [MEM_REQ_W-1:0] mem_req_in_data;
    logic [MEM_REQ_W-1:0] mem_req_out_data;
    logic [FWD_OUT_W-1:0] fwd_in_data;
    logic [FWD_OUT_W-1:0] fwd_out_data;

    // Address always in the low bits of each payload
    assign req_in_data = {req_in_coh_msg_i, req_in_hprot_i, req_in_line_i, req_in_req_id_i,
                          req_in_word_offset_i, req_in_valid_words_i, req_in_addr_i};
    assign {req_coh_msg_o, req_hprot_o, req_line_o, req_req_id_o,
            req_word_offset_o, req_valid_words_o, req_addr_o} = req_data;

    assign rsp_in_data = {rsp_in_coh_msg_i, rsp_in_line_i, rsp_in_req_id_i, rsp_in_addr_i};
    assign {rsp_coh_msg_o, rsp_line_o, rsp_req_id_o, rsp_addr_o} = rsp_data;

    assign mem_req_in_data = {mem_req_hwrite_i, mem_req_hsize_i, mem_req_hprot_i,
                              mem_req_line_i, mem_req_addr_i};
    assign {mem_req_hwrite_o, mem_req_hsize_o, mem_req_hprot_o,
            mem_req_line_o, mem_req_addr_o} = mem_req_out_data;

    assign fwd_in_data = {fwd_out_coh_msg_i, fwd_out_req_id_i, fwd_out_dest_id_i, fwd_out_addr_i};
    assign {fwd_out_coh_msg_o, fwd_out_req_id_o, fwd_out_dest_id_o, fwd_out_addr_o} = fwd_out_data;

    llc_req_in_stage #(.REQ_W(REQ_IN_W)) u_req_in (
        .clk (clk), .rst (rst),
        .req_in_valid_i (req_in_valid_i), .req_in_ready_o (req_in_ready_o),
        .req_in_data_i (req_in_data),
        .req_valid_o (req_valid_o), .req_ready_i (req_ready_i),
        .set_stalled_i (set_stalled_i), .replay_i (replay_i),
        .req_data_o (req_data),
        .req_in_addr_o (req_in_addr_o),
        .stalled_addr_o (req_in_stalled_addr_o),
        .recall_addr_o (req_in_recall_addr_o)
    );

    llc_rsp_in_stage #(.RSP_W(RSP_IN_W)) u_rsp_in (
        .clk (clk), .rst (rst),
        .rsp_in_valid_i (rsp_in_valid_i), .rsp_in_ready_o (rsp_in_ready_o),
        .rsp_in_data_i (rsp_in_data),
        .rsp_valid_o (rsp_valid_o), .rsp_ready_i (rsp_ready_i),
        .rsp_data_o (rsp_data),
        .rsp_in_addr_o (rsp_in_addr_o)
    );

    // Output channels drive the network pins directly
    llc_channel_buffer #(.WIDTH(MEM_REQ_W)) u_mem_req_buf (
        .clk (clk), .rst (rst),
        .src_valid_i (mem_req_valid_i), .src_ready_o (mem_req_ready_o),
        .src_data_i (mem_req_in_data),
        .dst_valid_o (mem_req_valid_o), .dst_ready_i (mem_req_ready_i),
        .dst_data_o (mem_req_out_data)
    );

    llc_channel_buffer #(.WIDTH(FWD_OUT_W)) u_fwd_out_buf (
        .clk (clk), .rst (rst),
        .src_valid_i (fwd_out_valid_i), .src_ready_o (fwd_out_ready_o),
        .src_data_i (fwd_in_data),
        .dst_valid_o (fwd_out_valid_o), .dst_ready_i (fwd_out_ready_i),
        .dst_data_o (fwd_out_data)
    );

endmodule

`default_nettype wire

// File: logic/llc_geom_pkg.sv
/* Address, line and word geometry widths of the cache controller */

`default_nettype none

package llc_geom_pkg;

    // Byte address and line offset
    localparam int ADDR_W = 32;
    localparam int OFFSET_W = 4;

    // Line address as seen by the channels
    localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

    // Words and lines
    localparam int WORD_W = 32;
    localparam int WORDS_PER_LINE = 2;
    localparam int WORD_OFF_W = $clog2(WORDS_PER_LINE);
    localparam int LINE_W = WORD_W * WORDS_PER_LINE;

endpackage

`default_nettype wire

// File: logic/llc_msg_pkg.sv
/* Message field widths and packed payload widths of the four channels */

`default_nettype none

package llc_msg_pkg;

    import llc_geom_pkg::*;

    // Field widths
    localparam int COH_MSG_W = 2;
    localparam int HPROT_W = 1;
    localparam int REQ_ID_W = 2;
    localparam int DEST_ID_W = 2;
    localparam int HSIZE_W = 3;

    // Coherence request: coh_msg, hprot, line, req_id, word_offset, valid_words, addr
    localparam int REQ_IN_W = COH_MSG_W + HPROT_W + LINE_W + REQ_ID_W
                            + WORD_OFF_W + WORD_OFF_W + LINE_ADDR_W;

    // Coherence response: coh_msg, line, req_id, addr
    localparam int RSP_IN_W = COH_MSG_W + LINE_W + REQ_ID_W + LINE_ADDR_W;

    // Memory request: hwrite, hsize, hprot, line, addr
    localparam int MEM_REQ_W = 1 + HSIZE_W + HPROT_W + LINE_W + LINE_ADDR_W;

    // Forward: coh_msg, req_id, dest_id, addr
    localparam int FWD_OUT_W = COH_MSG_W + REQ_ID_W + DEST_ID_W + LINE_ADDR_W;

endpackage

`default_nettype wire

// File: logic/llc_req_in_stage.sv
/* Coherence request input stage: channel buffer, capture register,
   stalled copy with replay and the request address taps */

`timescale 1ns/1ps
`default_nettype none

module llc_req_in_stage
    import llc_geom_pkg::*;
#(
    parameter int REQ_W = 99
) (
    input  logic                   clk,
    input  logic                   rst,

    // Network side
    input  logic                   req_in_valid_i,
    output logic                   req_in_ready_o,
    input  logic [REQ_W-1:0]       req_in_data_i,

    // Controller side
    output logic                   req_valid_o,
    input  logic                   req_ready_i,
    input  logic                   set_stalled_i,
    input  logic                   replay_i,
    output logic [REQ_W-1:0]       req_data_o,

    // Address taps
    output logic [LINE_ADDR_W-1:0] req_in_addr_o,
    output logic [LINE_ADDR_W-1:0] stalled_addr_o,
    output logic [LINE_ADDR_W-1:0] recall_addr_o
);

    logic [REQ_W-1:0] head_data;
    logic [REQ_W-1:0] req_q;
    logic [REQ_W-1:0] stalled_q;

    llc_channel_buffer #(
        .WIDTH (REQ_W)
    ) u_req_buf (
        .clk         (clk),
        .rst         (rst),
        .src_valid_i (req_in_valid_i),
        .src_ready_o (req_in_ready_o),
        .src_data_i  (req_in_data_i),
        .dst_valid_o (req_valid_o),
        .dst_ready_i (req_ready_i),
        .dst_data_o  (head_data)
    );

    // Replay wins over a new transfer in the same cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_q <= '0;
        end else if (replay_i) begin
            req_q <= stalled_q;
        end else if (req_valid_o && req_ready_i) begin
            req_q <= head_data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stalled_q <= '0;
        end else if (set_stalled_i) begin
            stalled_q <= req_q;
        end
    end

    assign req_data_o = req_q;

    // Line address sits in the low bits of the payload
    assign req_in_addr_o = head_data[LINE_ADDR_W-1:0];
    assign stalled_addr_o = stalled_q[LINE_ADDR_W-1:0];
    assign recall_addr_o = req_q[LINE_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: logic/llc_rsp_in_stage.sv
/* Coherence response input stage: channel buffer, capture register, address tap */

`timescale 1ns/1ps
`default_nettype none

module llc_rsp_in_stage
    import llc_geom_pkg::*;
#(
    parameter int RSP_W = 96
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   rsp_in_valid_i,
    output logic                   rsp_in_ready_o,
    input  logic [RSP_W-1:0]       rsp_in_data_i,

    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output logic [RSP_W-1:0]       rsp_data_o,

    output logic [LINE_ADDR_W-1:0] rsp_in_addr_o
);

    logic [RSP_W-1:0] head_data;
    logic [RSP_W-1:0] rsp_q;

    llc_channel_buffer #(
        .WIDTH (RSP_W)
    ) u_rsp_buf (
        .clk         (clk),
        .rst         (rst),
        .src_valid_i (rsp_in_valid_i),
        .src_ready_o (rsp_in_ready_o),
        .src_data_i  (rsp_in_data_i),
        .dst_valid_o (rsp_valid_o),
        .dst_ready_i (rsp_ready_i),
        .dst_data_o  (head_data)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_q <= '0;
        end else if (rsp_valid_o && rsp_ready_i) begin
            rsp_q <= head_data;
        end
    end

    assign rsp_data_o = rsp_q;
    assign rsp_in_addr_o = head_data[LINE_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: test/llc_channels_checker.sv
/* Queue models of the four channels, captured register models, error counts */

`timescale 1ns/1ps
`default_nettype none

module llc_channels_checker
    import llc_geom_pkg::*, llc_msg_pkg::*;
(
    input  logic                   clk, rst,
    input  logic                   req_src_valid, req_src_ready, req_dst_valid, req_dst_ready,
    input  logic [REQ_IN_W-1:0]    req_src_data, req_cap_data,
    input  logic                   set_stalled, replay,
    input  logic [LINE_ADDR_W-1:0] req_head_addr, stalled_addr, recall_addr, rsp_head_addr,
    input  logic                   rsp_src_valid, rsp_src_ready, rsp_dst_valid, rsp_dst_ready,
    input  logic [RSP_IN_W-1:0]    rsp_src_data, rsp_cap_data,
    input  logic                   mem_src_valid, mem_src_ready, mem_dst_valid, mem_dst_ready,
    input  logic [MEM_REQ_W-1:0]   mem_src_data, mem_dst_data,
    input  logic                   fwd_src_valid, fwd_src_ready, fwd_dst_valid, fwd_dst_ready,
    input  logic [FWD_OUT_W-1:0]   fwd_src_data, fwd_dst_data,
    output int                     errors_o,
    output int                     checks_o
);

    logic [REQ_IN_W-1:0]  req_q[$];
    logic [RSP_IN_W-1:0]  rsp_q[$];
    logic [MEM_REQ_W-1:0] mem_q[$];
    logic [FWD_OUT_W-1:0] fwd_q[$];
    logic [REQ_IN_W-1:0]  exp_req_cap, exp_stalled, req_item, prev_cap;
    logic [RSP_IN_W-1:0]  exp_rsp_cap;
    int                   errors = 0;
    int                   checks = 0;

    assign errors_o = errors;
    assign checks_o = checks;

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("%0t %s", $time, what);
    endtask

    // Inputs are settled half a cycle after they are driven
    always @(negedge clk) begin
        if (!rst) begin
            compare_value("ready outputs", {req_src_ready, rsp_src_ready, mem_src_ready,
                          fwd_src_ready}, 4'hf);
            compare_value("valid outputs", {req_dst_valid, rsp_dst_valid, mem_dst_valid,
                          fwd_dst_valid}, 4'h0);
            compare_value("req_data", req_cap_data, '0);
            compare_value("rsp_data", rsp_cap_data, '0);
            compare_value("req_in_stalled_addr_o", stalled_addr, '0);
            compare_value("req_in_recall_addr_o", recall_addr, '0);
            req_q.delete();
            rsp_q.delete();
            mem_q.delete();
            fwd_q.delete();
            exp_req_cap = '0;
            exp_stalled = '0;
            exp_rsp_cap = '0;
        end else begin
            compare_value("req_data", req_cap_data, exp_req_cap);
            compare_value("rsp_data", rsp_cap_data, exp_rsp_cap);
            compare_value("req_in_stalled_addr_o", stalled_addr, exp_stalled[LINE_ADDR_W-1:0]);
            compare_value("req_in_recall_addr_o", recall_addr, exp_req_cap[LINE_ADDR_W-1:0]);
            if (req_src_valid && req_src_ready) req_q.push_back(req_src_data);
            if (rsp_src_valid && rsp_src_ready) rsp_q.push_back(rsp_src_data);
            if (mem_src_valid && mem_src_ready) mem_q.push_back(mem_src_data);
            if (fwd_src_valid && fwd_src_ready) fwd_q.push_back(fwd_src_data);
            // Stalled copy and capture register both load from values before the edge
            prev_cap = exp_req_cap;
            if (req_dst_valid && req_q.size() == 0) begin
                report_error("request channel offers an item that was never sent");
            end else if (req_dst_valid) begin
                compare_value("req_in_addr_o", req_head_addr, req_q[0][LINE_ADDR_W-1:0]);
                if (req_dst_ready) req_item = req_q.pop_front();
                if (replay) exp_req_cap = exp_stalled;
                else if (req_dst_ready) exp_req_cap = req_item;
            end else if (replay) begin
                exp_req_cap = exp_stalled;
            end
            if (set_stalled) exp_stalled = prev_cap;
            if (rsp_dst_valid && rsp_q.size() == 0) begin
                report_error("response channel offers an item that was never sent");
            end else if (rsp_dst_valid) begin
                compare_value("rsp_in_addr_o", rsp_head_addr, rsp_q[0][LINE_ADDR_W-1:0]);
                if (rsp_dst_ready) exp_rsp_cap = rsp_q.pop_front();
            end
            if (mem_dst_valid && mem_q.size() == 0) begin
                report_error("memory request channel offers an item that was never sent");
            end else if (mem_dst_valid) begin
                compare_value("mem_req fields", mem_dst_data, mem_q[0]);
                if (mem_dst_ready) void'(mem_q.pop_front());
            end
            if (fwd_dst_valid && fwd_q.size() == 0) begin
                report_error("forward channel offers an item that was never sent");
            end else if (fwd_dst_valid) begin
                compare_value("fwd_out fields", fwd_dst_data, fwd_q[0]);
                if (fwd_dst_ready) void'(fwd_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// File: test/llc_channels_properties.sv
/* Channel buffer assertions, bound onto every llc_channel_buffer */

`timescale 1ns/1ps
`default_nettype none

module llc_channels_properties #(
    parameter int WIDTH = 32
) (
    input logic             clk,
    input logic             rst,
    input logic             src_ready_o,
    input logic             dst_valid_o,
    input logic             dst_ready_i,
    input logic [WIDTH-1:0] dst_data_o
);

    // Slot is free again once the destination takes its item
    ready_after_take: assert property (@(posedge clk) disable iff (!rst)
        dst_valid_o && dst_ready_i |=> src_ready_o)
        else $error("buffer not ready after its item was taken");

    // Offered item stays offered until taken
    valid_held: assert property (@(posedge clk) disable iff (!rst)
        dst_valid_o && !dst_ready_i |=> dst_valid_o)
        else $error("offered item dropped its valid before a transfer");

    data_held: assert property (@(posedge clk) disable iff (!rst)
        dst_valid_o && !dst_ready_i |=> $stable(dst_data_o))
        else $error("offered item changed under back-pressure");

endmodule

`default_nettype wire

// File: test/llc_channels_tb.sv
/* Testbench top: clock, reset, seeded random stimulus, timeout, DUT and checker */

`timescale 1ns/1ps
`default_nettype none

module llc_channels_tb
    import llc_geom_pkg::*, llc_msg_pkg::*;
();

    localparam int TEST_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

    logic clk, rst;
    logic [COH_MSG_W-1:0] req_in_coh_msg_i, req_coh_msg_o, rsp_in_coh_msg_i, rsp_coh_msg_o;
    logic [COH_MSG_W-1:0] fwd_out_coh_msg_i, fwd_out_coh_msg_o;
    logic [HPROT_W-1:0] req_in_hprot_i, req_hprot_o, mem_req_hprot_i, mem_req_hprot_o;
    logic [LINE_ADDR_W-1:0] req_in_addr_i, req_addr_o, rsp_in_addr_i, rsp_addr_o;
    logic [LINE_ADDR_W-1:0] mem_req_addr_i, mem_req_addr_o, fwd_out_addr_i, fwd_out_addr_o;
    logic [LINE_ADDR_W-1:0] req_in_addr_o, rsp_in_addr_o;
    logic [LINE_ADDR_W-1:0] req_in_stalled_addr_o, req_in_recall_addr_o;
    logic [LINE_W-1:0] req_in_line_i, req_line_o, rsp_in_line_i, rsp_line_o;
    logic [LINE_W-1:0] mem_req_line_i, mem_req_line_o;
    logic [REQ_ID_W-1:0] req_in_req_id_i, req_req_id_o, rsp_in_req_id_i, rsp_req_id_o;
    logic [REQ_ID_W-1:0] fwd_out_req_id_i, fwd_out_req_id_o;
    logic [DEST_ID_W-1:0] fwd_out_dest_id_i, fwd_out_dest_id_o;
    logic [WORD_OFF_W-1:0] req_in_word_offset_i, req_word_offset_o;
    logic [WORD_OFF_W-1:0] req_in_valid_words_i, req_valid_words_o;
    logic [HSIZE_W-1:0] mem_req_hsize_i, mem_req_hsize_o;
    logic mem_req_hwrite_i, mem_req_hwrite_o, set_stalled_i, replay_i;
    logic req_in_valid_i, req_in_ready_o, req_valid_o, req_ready_i;
    logic rsp_in_valid_i, rsp_in_ready_o, rsp_valid_o, rsp_ready_i;
    logic mem_req_valid_i, mem_req_ready_o, mem_req_valid_o, mem_req_ready_i;
    logic fwd_out_valid_i, fwd_out_ready_o, fwd_out_valid_o, fwd_out_ready_i;
    integer seed = 16;
    int cycles = 0;
    int errors, checks;

    llc_channels u_llc_channels (.*);

    bind llc_channel_buffer llc_channels_properties #(.WIDTH(WIDTH)) u_props (
        .clk (clk), .rst (rst), .src_ready_o (src_ready_o),
        .dst_valid_o (dst_valid_o), .dst_ready_i (dst_ready_i), .dst_data_o (dst_data_o)
    );

    llc_channels_checker u_checker (
        .clk (clk), .rst (rst),
        .req_src_valid (req_in_valid_i), .req_src_ready (req_in_ready_o),
        .req_dst_valid (req_valid_o), .req_dst_ready (req_ready_i),
        .req_src_data ({req_in_coh_msg_i, req_in_hprot_i, req_in_line_i, req_in_req_id_i,
                        req_in_word_offset_i, req_in_valid_words_i, req_in_addr_i}),
        .req_cap_data ({req_coh_msg_o, req_hprot_o, req_line_o, req_req_id_o,
                        req_word_offset_o, req_valid_words_o, req_addr_o}),
        .set_stalled (set_stalled_i), .replay (replay_i),
        .req_head_addr (req_in_addr_o), .stalled_addr (req_in_stalled_addr_o),
        .recall_addr (req_in_recall_addr_o), .rsp_head_addr (rsp_in_addr_o),
        .rsp_src_valid (rsp_in_valid_i), .rsp_src_ready (rsp_in_ready_o),
        .rsp_dst_valid (rsp_valid_o), .rsp_dst_ready (rsp_ready_i),
        .rsp_src_data ({rsp_in_coh_msg_i, rsp_in_line_i, rsp_in_req_id_i, rsp_in_addr_i}),
        .rsp_cap_data ({rsp_coh_msg_o, rsp_line_o, rsp_req_id_o, rsp_addr_o}),
        .mem_src_valid (mem_req_valid_i), .mem_src_ready (mem_req_ready_o),
        .mem_dst_valid (mem_req_valid_o), .mem_dst_ready (mem_req_ready_i),
        .mem_src_data ({mem_req_hwrite_i, mem_req_hsize_i, mem_req_hprot_i, mem_req_line_i,
                        mem_req_addr_i}),
        .mem_dst_data ({mem_req_hwrite_o, mem_req_hsize_o, mem_req_hprot_o, mem_req_line_o,
                        mem_req_addr_o}),
        .fwd_src_valid (fwd_out_valid_i), .fwd_src_ready (fwd_out_ready_o),
        .fwd_dst_valid (fwd_out_valid_o), .fwd_dst_ready (fwd_out_ready_i),
        .fwd_src_data ({fwd_out_coh_msg_i, fwd_out_req_id_i, fwd_out_dest_id_i, fwd_out_addr_i}),
        .fwd_dst_data ({fwd_out_coh_msg_o, fwd_out_req_id_o, fwd_out_dest_id_o, fwd_out_addr_o}),
        .errors_o (errors), .checks_o (checks)
    );

    initial clk = 1'b0;
    always #5 clk = !clk;

    // Fields change every cycle, valids and readies at random
    task automatic drive_random();
        req_in_coh_msg_i = COH_MSG_W'($random(seed));
        req_in_hprot_i = HPROT_W'($random(seed));
        req_in_req_id_i = REQ_ID_W'($random(seed));
        req_in_word_offset_i = WORD_OFF_W'($random(seed));
        req_in_valid_words_i = WORD_OFF_W'($random(seed));
        req_in_addr_i = LINE_ADDR_W'($random(seed));
        req_in_line_i = {$random(seed), $random(seed)};
        rsp_in_coh_msg_i = COH_MSG_W'($random(seed));
        rsp_in_req_id_i = REQ_ID_W'($random(seed));
        rsp_in_addr_i = LINE_ADDR_W'($random(seed));
        rsp_in_line_i = {$random(seed), $random(seed)};
        mem_req_hwrite_i = 1'($random(seed));
        mem_req_hsize_i = HSIZE_W'($random(seed));
        mem_req_hprot_i = HPROT_W'($random(seed));
        mem_req_addr_i = LINE_ADDR_W'($random(seed));
        mem_req_line_i = {$random(seed), $random(seed)};
        fwd_out_coh_msg_i = COH_MSG_W'($random(seed));
        fwd_out_req_id_i = REQ_ID_W'($random(seed));
        fwd_out_dest_id_i = DEST_ID_W'($random(seed));
        fwd_out_addr_i = LINE_ADDR_W'($random(seed));
        req_in_valid_i = 1'($random(seed));
        rsp_in_valid_i = 1'($random(seed));
        mem_req_valid_i = 1'($random(seed));
        fwd_out_valid_i = 1'($random(seed));
        req_ready_i = ($random(seed) % 4) != 0;
        rsp_ready_i = ($random(seed) % 4) != 0;
        mem_req_ready_i = ($random(seed) % 3) != 0;
        fwd_out_ready_i = ($random(seed) % 3) != 0;
        set_stalled_i = ($random(seed) % 8) == 0;
        replay_i = ($random(seed) % 12) == 0;
    endtask

    initial begin
        {req_in_coh_msg_i, req_in_hprot_i, req_in_addr_i, req_in_line_i, req_in_req_id_i} = '0;
        {req_in_word_offset_i, req_in_valid_words_i, req_in_valid_i, req_ready_i} = '0;
        {set_stalled_i, replay_i, rsp_in_coh_msg_i, rsp_in_addr_i, rsp_in_line_i} = '0;
        {rsp_in_req_id_i, rsp_in_valid_i, rsp_ready_i, mem_req_hwrite_i, mem_req_hsize_i} = '0;
        {mem_req_hprot_i, mem_req_addr_i, mem_req_line_i, mem_req_valid_i} = '0;
        {mem_req_ready_i, fwd_out_coh_msg_i, fwd_out_addr_i, fwd_out_req_id_i} = '0;
        {fwd_out_dest_id_i, fwd_out_valid_i, fwd_out_ready_i} = '0;
        rst = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b1;
        repeat (TEST_CYCLES) begin
            @(posedge clk);
            #1 drive_random();
        end
        // Checker has compared the last cycle by the next rising edge
        @(posedge clk);
        $display("Closing count: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES + 10) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

endmodule

`default_nettype wire
